// ==== build.f ====
logic/cpuCtrlPkg.sv
logic/instrDecoder.sv
logic/stepSequencer.sv
logic/controlWordGen.sv
logic/controlUnit.sv
dv/clockGen.sv
dv/controlUnit_asserts.sv
dv/controlUnitTb.sv

// ==== Makefile ====
# Verilator flow for the control unit testbench

VERILATOR ?= verilator
TOP       ?= controlUnitTb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -j 0
LINTFLAGS ?= --lint-only --timing
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= TESTS FAILED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi; \
	exit $$status

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/controlUnitTb.sv ====
module controlUnitTb;
    import cpuCtrlPkg::*;

    localparam int MaxCycles = 10;      // longest word takes 3
    localparam int ResetLimit = 20;

    logic                   clk;
    logic                   reset;
    logic [InstrWidth-1:0]  iMemOut;
    logic                   carryFlag;
    logic                   zeroFlag;
    logic                   negativeFlag;
    regFileSrc_e            regFileSrc;
    logic [RegSelWidth-1:0] regFileOutBSelect;
    logic                   regFileWriteEnable;
    logic                   regFileIncPair;
    logic                   regFileDecPair;
    logic [1:0]             aluSrcBSelect;
    aluMode_e               aluMode;
    dMemDataSel_e           dMemDataSelect;
    dMemAddrSel_e           dMemIOAddressSelect;
    logic                   dMemIOWriteEn;
    logic                   dMemIOReadEn;
    logic                   flagEnable;
    iMemAddrSel_e           iMemAddrSelect;
    logic                   iMemReadEnable;
    logic                   pcWriteEn;

    logic [31:0] lfsr = 32'd65834;
    int          testCount = 0;
    int          failedTests = 0;
    int          failBase = 0;
    string       stallNote = "";        // set when a wait runs out

    bind controlUnit controlUnit_asserts #(.StackPair(StackPair)) asserts_i (.*);

    clockGen clockGen_i (
        .clk   (clk),
        .reset (reset)
    );

    controlUnit controlUnit_i (.*);

    function automatic logic takeBit();
        logic out;
        out = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'h8020_0003;    // x^32 + x^22 + x^2 + x + 1
        end
        return out;
    endfunction

    function automatic logic [15:0] randomBits(input int count);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[14:0], takeBit()};
        end
        return value;
    endfunction

    function automatic int assertFailures();
        return controlUnit_i.asserts_i.failCount;
    endfunction

    // holds one word until pcWriteEn, then a NOP cycle follows
    task automatic execWord(input logic [15:0] word);
        int cycles;
        @(posedge clk);
        iMemOut <= word;
        carryFlag <= takeBit();
        zeroFlag <= takeBit();
        negativeFlag <= takeBit();
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!pcWriteEn && cycles < MaxCycles);
        if (!pcWriteEn) begin
            stallNote = "pcWriteEn never rose";
        end
        @(posedge clk);
        iMemOut <= '0;
    endtask

    task automatic endTest(input string name);
        int newFails;
        @(negedge clk);    // checks of the last edge are in by now
        newFails = assertFailures() - failBase;
        testCount++;
        if (stallNote != "") begin
            $display("%s: %s within %0d cycles", name, stallNote, MaxCycles);
            failedTests++;
        end else if (newFails != 0) begin
            $display("[ERROR] %s: expected 0 assertion failures, actual %0d", name, newFails);
            failedTests++;
        end else begin
            $display("%s: ok", name);
        end
        failBase = assertFailures();
        stallNote = "";
    endtask

    initial begin
        logic [15:0] r;
        logic [15:0] word;
        int          cycles;
        iMemOut = '0;
        carryFlag = 1'b0;
        zeroFlag = 1'b0;
        negativeFlag = 1'b0;

        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (reset && cycles < ResetLimit);
        if (reset) begin
            stallNote = "reset never fell";
        end
        endTest("reset");

        for (int i = 0; i < 7; i++) begin
            r = randomBits(12);
            execWord({r[11:0], 3'(i), 1'b1});    // field 0 is load-immediate
        end
        endTest("alu immediate");

        for (int i = 1; i <= 12; i++) begin
            r = randomBits(8);
            execWord({r[7:0], 5'(i), 3'b000});
        end
        endTest("alu register");

        for (int i = 0; i < 4; i++) begin
            r = randomBits(13);
            execWord({r[12:0], 3'b010});
        end
        for (int f = 16; f <= 18; f++) begin
            r = randomBits(8);
            execWord({r[7:0], 5'(f), 3'b000});
        end
        endTest("in and load");

        for (int i = 0; i < 10; i++) begin
            r = randomBits(8);
            word = {r[7:0], (i % 2 == 0) ? 5'd22 : 5'd21, 3'b000};
            if (i < 2) begin
                word[15:13] = 3'b111;    // always taken
            end
            execWord(word);
        end
        endTest("jumps");

        for (int i = 0; i < 8; i++) begin
            r = randomBits(8);
            word = {r[7:0], 5'd23, 3'b000};
            if (i == 0) begin
                word[15:13] = 3'b000;
            end
            execWord(word);
        end
        endTest("call");

        for (int i = 0; i < 8; i++) begin
            r = randomBits(8);
            word = {r[7:0], 5'd24, 3'b000};
            if (i == 0) begin
                word[15:13] = 3'b000;
            end
            execWord(word);
        end
        endTest("ret");

        @(posedge clk);
        iMemOut <= {8'h00, 5'd29, 3'b000};
        repeat (5) @(posedge clk);    // HLT held for 5 cycles
        iMemOut <= '0;
        endTest("halt");

        $display("%0d tests run, %0d failed, %0d assertion failures",
            testCount, failedTests, assertFailures());
        if (failedTests == 0 && assertFailures() == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/controlUnit_asserts.sv ====
module controlUnit_asserts #(
    parameter int StackPair = cpuCtrlPkg::DefaultStackPair
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [cpuCtrlPkg::InstrWidth-1:0]  iMemOut,
    input  logic                               carryFlag,
    input  logic                               zeroFlag,
    input  logic                               negativeFlag,
    input  cpuCtrlPkg::regFileSrc_e            regFileSrc,
    input  logic [cpuCtrlPkg::RegSelWidth-1:0] regFileOutBSelect,
    input  logic                               regFileWriteEnable,
    input  logic                               regFileIncPair,
    input  logic                               regFileDecPair,
    input  logic [1:0]                         aluSrcBSelect,
    input  cpuCtrlPkg::aluMode_e               aluMode,
    input  cpuCtrlPkg::dMemDataSel_e           dMemDataSelect,
    input  cpuCtrlPkg::dMemAddrSel_e           dMemIOAddressSelect,
    input  logic                               dMemIOWriteEn,
    input  logic                               dMemIOReadEn,
    input  logic                               flagEnable,
    input  cpuCtrlPkg::iMemAddrSel_e           iMemAddrSelect,
    input  logic                               iMemReadEnable,
    input  logic                               pcWriteEn
);
    import cpuCtrlPkg::*;

    int failCount = 0;

    logic [4:0] func;
    logic       rType;
    logic       isImm;
    logic       isIn;
    logic       isLoad;
    logic       isAluReg;
    logic       taken;
    logic       afterReset;     // reset was high last cycle
    logic       fresh;          // first execute cycle of a word
    logic       dataStart;
    logic       jumpStart;
    logic       callStart;
    logic       retStart;

    assign func = iMemOut[7:3];
    assign rType = (iMemOut[2:0] == 3'b000);
    assign isImm = iMemOut[0] && (iMemOut[3:1] != 3'b111);
    assign isIn = (iMemOut[2:0] == 3'b010);
    assign isLoad = rType && func >= 5'd16 && func <= 5'd18;
    assign isAluReg = rType && func >= 5'd1 && func <= 5'd12;

    // codes 1..6 pick a flag or its inverse
    assign taken = (iMemOut[15:13] == 3'd0) || (iMemOut[15:13] == 3'd7)
        || (iMemOut[15:13] == 3'd1 && carryFlag) || (iMemOut[15:13] == 3'd2 && !carryFlag)
        || (iMemOut[15:13] == 3'd3 && zeroFlag) || (iMemOut[15:13] == 3'd4 && !zeroFlag)
        || (iMemOut[15:13] == 3'd5 && negativeFlag)
        || (iMemOut[15:13] == 3'd6 && !negativeFlag);

    assign dataStart = fresh && (isIn || isLoad);
    assign jumpStart = fresh && rType && func == 5'd22 && taken;
    assign callStart = fresh && rType && func == 5'd23 && taken;
    assign retStart = fresh && rType && func == 5'd24 && taken;

    always_ff @(posedge clk) begin
        afterReset <= reset;
        fresh <= !reset && (afterReset || pcWriteEn);
    end

    resetIdle: assert property (@(posedge clk) afterReset |-> !(regFileWriteEnable
        || regFileIncPair || regFileDecPair || dMemIOWriteEn || dMemIOReadEn
        || flagEnable || iMemReadEnable || pcWriteEn))
    else begin
        $error("enable active during reset or the idle cycle");
        failCount++;
    end

    immWord: assert property (@(posedge clk) disable iff (reset)
        fresh && isImm |-> regFileWriteEnable && pcWriteEn && aluSrcBSelect == 2'd2
            && aluMode == 4'(iMemOut[3:1])
            && flagEnable == (iMemOut[3:1] != 3'd0))
    else begin
        $error("immediate ALU word gave a wrong control word");
        failCount++;
    end

    aluRegWord: assert property (@(posedge clk) disable iff (reset)
        fresh && isAluReg |-> flagEnable && pcWriteEn && regFileOutBSelect == iMemOut[11:8])
    else begin
        $error("register ALU word gave a wrong control word");
        failCount++;
    end

    dataFirst: assert property (@(posedge clk) disable iff (reset)
        dataStart |-> dMemIOReadEn && !pcWriteEn && !regFileWriteEnable)
    else begin
        $error("IN or load first cycle wrong");
        failCount++;
    end

    dataSecond: assert property (@(posedge clk) disable iff (reset)
        $past(dataStart) |-> pcWriteEn && regFileWriteEnable && regFileSrc == selMemData
            && (!isIn || dMemIOAddressSelect == selPortAddr))
    else begin
        $error("IN or load second cycle wrong");
        failCount++;
    end

    jumpFirst: assert property (@(posedge clk) disable iff (reset)
        jumpStart |-> !pcWriteEn && iMemAddrSelect == selPcOut)
    else begin
        $error("taken absolute jump first cycle wrong");
        failCount++;
    end

    jumpSecond: assert property (@(posedge clk) disable iff (reset)
        $past(jumpStart) |-> pcWriteEn && iMemAddrSelect == selInstrWord)
    else begin
        $error("taken absolute jump did not load the target word");
        failCount++;
    end

    jumpSkip: assert property (@(posedge clk) disable iff (reset)
        fresh && rType && func == 5'd22 && !taken |-> pcWriteEn
            && iMemAddrSelect == selPcPlusOne)
    else begin
        $error("untaken absolute jump did not skip the address word");
        failCount++;
    end

    jumpPair: assert property (@(posedge clk) disable iff (reset)
        fresh && rType && func == 5'd21 && taken |-> pcWriteEn
            && iMemAddrSelect == selPairAddr)
    else begin
        $error("taken pair jump did not select the pair address");
        failCount++;
    end

    callLow: assert property (@(posedge clk) disable iff (reset)
        callStart |-> dMemIOWriteEn && regFileDecPair && dMemDataSelect == selPcLow
            && !pcWriteEn && regFileOutBSelect == RegSelWidth'(StackPair))
    else begin
        $error("CALL low byte push wrong");
        failCount++;
    end

    callHigh: assert property (@(posedge clk) disable iff (reset)
        $past(callStart) |-> dMemIOWriteEn && regFileDecPair && dMemDataSelect == selPcHigh
            && pcWriteEn && regFileOutBSelect == RegSelWidth'(StackPair))
    else begin
        $error("CALL high byte push wrong");
        failCount++;
    end

    retWait: assert property (@(posedge clk) disable iff (reset)
        retStart || $past(retStart) |-> !pcWriteEn)
    else begin
        $error("RET wrote the PC before its third cycle");
        failCount++;
    end

    retLoad: assert property (@(posedge clk) disable iff (reset)
        $past(retStart, 2) |-> pcWriteEn && iMemAddrSelect == selReturnAddr)
    else begin
        $error("RET third cycle did not load the return address");
        failCount++;
    end

    haltHold: assert property (@(posedge clk) disable iff (reset)
        rType && func == 5'd29 |-> !pcWriteEn && !iMemReadEnable)
    else begin
        $error("HLT let the PC or fetch run");
        failCount++;
    end

endmodule

// ==== dv/clockGen.sv ====
module clockGen (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;    // period 8
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== logic/controlUnit.sv ====
module controlUnit #(
    parameter int StackPair = cpuCtrlPkg::DefaultStackPair
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [cpuCtrlPkg::InstrWidth-1:0]  iMemOut,
    input  logic                               carryFlag,
    input  logic                               zeroFlag,
    input  logic                               negativeFlag,
    output cpuCtrlPkg::regFileSrc_e            regFileSrc,
    output logic [cpuCtrlPkg::RegSelWidth-1:0] regFileOutBSelect,
    output logic                               regFileWriteEnable,
    output logic                               regFileIncPair,
    output logic                               regFileDecPair,
    output logic [1:0]                         aluSrcBSelect,
    output cpuCtrlPkg::aluMode_e               aluMode,
    output cpuCtrlPkg::dMemDataSel_e           dMemDataSelect,
    output cpuCtrlPkg::dMemAddrSel_e           dMemIOAddressSelect,
    output logic                               dMemIOWriteEn,
    output logic                               dMemIOReadEn,
    output logic                               flagEnable,
    output cpuCtrlPkg::iMemAddrSel_e           iMemAddrSelect,
    output logic                               iMemReadEnable,
    output logic                               pcWriteEn
);
    import cpuCtrlPkg::*;

    opcode_e                opcode;
    aluMode_e               aluField;
    logic [RegSelWidth-1:0] destField;
    logic [RegSelWidth-1:0] srcField;
    logic [2:0]             pairField;
    pairMode_e              pairMode;
    logic                   condMet;
    step_e                  step;

    instrDecoder decoder_i (
        .iMemOut      (iMemOut),
        .carryFlag    (carryFlag),
        .zeroFlag     (zeroFlag),
        .negativeFlag (negativeFlag),
        .opcode       (opcode),
        .aluField     (aluField),
        .destField    (destField),
        .srcField     (srcField),
        .pairField    (pairField),
        .pairMode     (pairMode),
        .condMet      (condMet)
    );

    stepSequencer sequencer_i (
        .clk     (clk),
        .reset   (reset),
        .opcode  (opcode),
        .condMet (condMet),
        .step    (step)
    );

    controlWordGen #(
        .StackPair (StackPair)
    ) wordGen_i (
        .step                (step),
        .opcode              (opcode),
        .aluField            (aluField),
        .destField           (destField),
        .srcField            (srcField),
        .pairField           (pairField),
        .pairMode            (pairMode),
        .condMet             (condMet),
        .regFileSrc          (regFileSrc),
        .regFileOutBSelect   (regFileOutBSelect),
        .regFileWriteEnable  (regFileWriteEnable),
        .regFileIncPair      (regFileIncPair),
        .regFileDecPair      (regFileDecPair),
        .aluSrcBSelect       (aluSrcBSelect),
        .aluMode             (aluMode),
        .dMemDataSelect      (dMemDataSelect),
        .dMemIOAddressSelect (dMemIOAddressSelect),
        .dMemIOWriteEn       (dMemIOWriteEn),
        .dMemIOReadEn        (dMemIOReadEn),
        .flagEnable          (flagEnable),
        .iMemAddrSelect      (iMemAddrSelect),
        .iMemReadEnable      (iMemReadEnable),
        .pcWriteEn           (pcWriteEn)
    );

endmodule

// ==== logic/controlWordGen.sv ====
module controlWordGen #(
    parameter int StackPair = cpuCtrlPkg::DefaultStackPair
) (
    input  cpuCtrlPkg::step_e                  step,
    input  cpuCtrlPkg::opcode_e                opcode,
    input  cpuCtrlPkg::aluMode_e               aluField,
    input  logic [cpuCtrlPkg::RegSelWidth-1:0] destField,
    input  logic [cpuCtrlPkg::RegSelWidth-1:0] srcField,
    input  logic [2:0]                         pairField,
    input  cpuCtrlPkg::pairMode_e              pairMode,
    input  logic                               condMet,
    output cpuCtrlPkg::regFileSrc_e            regFileSrc,
    output logic [cpuCtrlPkg::RegSelWidth-1:0] regFileOutBSelect,
    output logic                               regFileWriteEnable,
    output logic                               regFileIncPair,
    output logic                               regFileDecPair,
    output logic [1:0]                         aluSrcBSelect,
    output cpuCtrlPkg::aluMode_e               aluMode,
    output cpuCtrlPkg::dMemDataSel_e           dMemDataSelect,
    output cpuCtrlPkg::dMemAddrSel_e           dMemIOAddressSelect,
    output logic                               dMemIOWriteEn,
    output logic                               dMemIOReadEn,
    output logic                               flagEnable,
    output cpuCtrlPkg::iMemAddrSel_e           iMemAddrSelect,
    output logic                               iMemReadEnable,
    output logic                               pcWriteEn
);
    import cpuCtrlPkg::*;

    logic [RegSelWidth-1:0] pairReg;
    logic [RegSelWidth-1:0] stackReg;
    logic                   stepInc;
    logic                   stepDec;

    assign pairReg = {pairField, 1'b0};    // low register of the pair
    assign stackReg = RegSelWidth'(StackPair);
    assign stepInc = (pairMode == pairInc);
    assign stepDec = (pairMode == pairDec);

    always_comb begin
        regFileSrc = selAluResult;
        regFileOutBSelect = destField;
        regFileWriteEnable = 1'b0;
        regFileIncPair = 1'b0;
        regFileDecPair = 1'b0;
        aluSrcBSelect = 2'd0;          // register operand
        aluMode = aluPassB;
        dMemDataSelect = selAluOut;
        dMemIOAddressSelect = selPairPtr;
        dMemIOWriteEn = 1'b0;
        dMemIOReadEn = 1'b0;
        flagEnable = 1'b0;
        iMemAddrSelect = selPcOut;
        iMemReadEnable = 1'b1;
        pcWriteEn = 1'b1;

        case (step)
            stIdle: begin
                iMemReadEnable = 1'b0;
                pcWriteEn = 1'b0;
            end
            stExecute: begin
                case (opcode)
                    opLoadImm, opAluImm: begin
                        regFileWriteEnable = 1'b1;
                        aluSrcBSelect = 2'd2;    // 8-bit immediate
                        aluMode = aluField;
                        flagEnable = (opcode == opAluImm);    // LDI leaves flags alone
                    end
                    opAluReg: begin
                        regFileOutBSelect = srcField;
                        regFileWriteEnable = 1'b1;
                        aluMode = aluField;
                        flagEnable = 1'b1;
                    end
                    opIn: begin
                        regFileSrc = selMemData;
                        dMemIOAddressSelect = selPortAddr;
                        dMemIOReadEn = 1'b1;
                        iMemReadEnable = 1'b0;
                        pcWriteEn = 1'b0;
                    end
                    opOut: begin
                        dMemIOAddressSelect = selPortAddr;
                        dMemIOWriteEn = 1'b1;
                    end
                    opStore: begin
                        regFileOutBSelect = pairReg;
                        aluMode = aluPassA;
                        dMemIOWriteEn = 1'b1;
                        regFileIncPair = stepInc;
                        regFileDecPair = stepDec;
                    end
                    opLoad: begin
                        regFileSrc = selMemData;
                        regFileOutBSelect = pairReg;
                        dMemIOReadEn = 1'b1;
                        iMemReadEnable = 1'b0;
                        pcWriteEn = 1'b0;
                    end
                    opPairStep: begin
                        regFileOutBSelect = pairReg;
                        regFileIncPair = stepInc;
                        regFileDecPair = stepDec;
                    end
                    opJumpPair: begin
                        regFileOutBSelect = pairReg;
                        iMemAddrSelect = condMet ? selPairAddr : selPcOut;
                    end
                    opJumpAbs: begin
                        if (condMet) begin
                            pcWriteEn = 1'b0;    // fetch the address word first
                        end else begin
                            iMemAddrSelect = selPcPlusOne;
                        end
                    end
                    opCall: begin
                        regFileOutBSelect = stackReg;
                        dMemDataSelect = selPcLow;
                        if (condMet) begin
                            regFileDecPair = 1'b1;
                            dMemIOWriteEn = 1'b1;    // push low byte of return address
                            pcWriteEn = 1'b0;
                        end else begin
                            iMemAddrSelect = selPcPlusOne;
                        end
                    end
                    opRet: begin
                        regFileOutBSelect = stackReg;
                        dMemIOAddressSelect = selPairPtrPlusOne;
                        dMemIOReadEn = 1'b1;
                        if (condMet) begin
                            regFileIncPair = 1'b1;
                            iMemAddrSelect = selReturnAddr;
                            iMemReadEnable = 1'b0;
                            pcWriteEn = 1'b0;
                        end
                    end
                    opHalt: begin
                        iMemReadEnable = 1'b0;
                        pcWriteEn = 1'b0;
                    end
                    default: begin
                    end
                endcase
            end
            stDataWait: begin
                regFileSrc = selMemData;
                regFileWriteEnable = 1'b1;
                dMemIOReadEn = 1'b1;
                if (opcode == opIn) begin
                    dMemIOAddressSelect = selPortAddr;
                end else begin
                    regFileOutBSelect = pairReg;
                    regFileIncPair = stepInc;    // pointer moves once the data is in
                    regFileDecPair = stepDec;
                end
            end
            stJumpLoad: begin
                iMemAddrSelect = selInstrWord;
            end
            stCallHigh: begin
                regFileOutBSelect = stackReg;
                regFileDecPair = 1'b1;
                dMemDataSelect = selPcHigh;
                dMemIOWriteEn = 1'b1;
                iMemAddrSelect = selInstrWord;    // target word read last cycle
            end
            stRetPop, stRetLoad: begin
                regFileOutBSelect = stackReg;
                dMemIOAddressSelect = selPairPtrPlusOne;
                dMemIOReadEn = 1'b1;
                iMemAddrSelect = selReturnAddr;
                if (step == stRetPop) begin
                    regFileIncPair = 1'b1;
                    iMemReadEnable = 1'b0;
                    pcWriteEn = 1'b0;
                end
            end
            default: begin
                iMemReadEnable = 1'b0;
                pcWriteEn = 1'b0;
            end
        endcase
    end

endmodule

// ==== logic/stepSequencer.sv ====
module stepSequencer (
    input  logic                clk,
    input  logic                reset,
    input  cpuCtrlPkg::opcode_e opcode,
    input  logic                condMet,
    output cpuCtrlPkg::step_e   step
);
    import cpuCtrlPkg::*;

    step_e nextStep;

    always_ff @(posedge clk) begin
        if (reset) begin
            step <= stIdle;
        end else begin
            step <= nextStep;
        end
    end

    always_comb begin
        nextStep = stExecute;
        case (step)
            stExecute: begin
                case (opcode)
                    opIn, opLoad: nextStep = stDataWait;
                    opJumpAbs: nextStep = condMet ? stJumpLoad : stExecute;
                    opCall: nextStep = condMet ? stCallHigh : stExecute;
                    opRet: nextStep = condMet ? stRetPop : stExecute;
                    default: nextStep = stExecute;
                endcase
            end
            stRetPop: nextStep = stRetLoad;    // second pop cycle
            default: nextStep = stExecute;
        endcase
    end

endmodule

// ==== logic/instrDecoder.sv ====
module instrDecoder (
    input  logic [cpuCtrlPkg::InstrWidth-1:0]  iMemOut,
    input  logic                               carryFlag,
    input  logic                               zeroFlag,
    input  logic                               negativeFlag,
    output cpuCtrlPkg::opcode_e                opcode,
    output cpuCtrlPkg::aluMode_e               aluField,
    output logic [cpuCtrlPkg::RegSelWidth-1:0] destField,
    output logic [cpuCtrlPkg::RegSelWidth-1:0] srcField,
    output logic [2:0]                         pairField,
    output cpuCtrlPkg::pairMode_e              pairMode,
    output logic                               condMet
);
    import cpuCtrlPkg::*;

    logic [4:0] func;   // function field of the R-type words
    logic [2:0] low;

    assign func = iMemOut[7:3];
    assign low = iMemOut[2:0];

    assign destField = iMemOut[15:12];
    assign srcField = iMemOut[11:8];
    assign pairField = iMemOut[11:9];

    always_comb begin
        case (iMemOut[15:13])
            3'd1: condMet = carryFlag;
            3'd2: condMet = ~carryFlag;
            3'd3: condMet = zeroFlag;
            3'd4: condMet = ~zeroFlag;
            3'd5: condMet = negativeFlag;
            3'd6: condMet = ~negativeFlag;
            default: condMet = 1'b1;    // 0 and 7 are unconditional
        endcase
    end

    always_comb begin
        opcode = opNop;
        aluField = aluPassB;
        pairMode = pairKeep;
        if (iMemOut[0] && iMemOut[3:1] != 3'b111) begin
            aluField = aluMode_e'({1'b0, iMemOut[3:1]});
            opcode = (iMemOut[3:1] == 3'b000) ? opLoadImm : opAluImm;
        end else if (low == 3'b010) begin
            opcode = opIn;
        end else if (low == 3'b100) begin
            opcode = opOut;
        end else if (low == 3'b000) begin
            if (func >= 5'd1 && func <= 5'd12) begin
                opcode = opAluReg;
                aluField = aluMode_e'(iMemOut[6:3]);
            end else if (func >= 5'd13 && func <= 5'd18) begin
                opcode = iMemOut[7] ? opLoad : opStore;    // 16 to 18 load
                case (func)
                    5'd14, 5'd17: pairMode = pairInc;
                    5'd15, 5'd18: pairMode = pairDec;
                    default: pairMode = pairKeep;
                endcase
            end else begin
                case (func)
                    5'd19: begin
                        opcode = opPairStep;
                        pairMode = pairInc;
                    end
                    5'd20: begin
                        opcode = opPairStep;
                        pairMode = pairDec;
                    end
                    5'd21: opcode = opJumpPair;
                    5'd22: opcode = opJumpAbs;
                    5'd23: opcode = opCall;
                    5'd24: opcode = opRet;
                    5'd29: opcode = opHalt;
                    default: opcode = opNop;
                endcase
            end
        end
    end

endmodule

// ==== logic/cpuCtrlPkg.sv ====
package cpuCtrlPkg;

    localparam int InstrWidth = 16;
    localparam int RegSelWidth = 4;
    localparam int DefaultStackPair = 14;     // low byte of the stack pointer pair

    typedef enum logic [3:0] {
        opLoadImm,
        opAluImm,
        opAluReg,
        opIn,
        opOut,
        opStore,
        opLoad,
        opPairStep,
        opJumpPair,
        opJumpAbs,
        opCall,
        opRet,
        opHalt,
        opNop
    } opcode_e;

    typedef enum logic [1:0] {
        pairKeep,
        pairInc,
        pairDec
    } pairMode_e;

    typedef enum logic [3:0] {
        aluPassB = 4'd0,
        aluAnd   = 4'd1,
        aluOr    = 4'd2,
        aluXor   = 4'd3,
        aluAdd   = 4'd4,
        aluAddC  = 4'd5,
        aluSub   = 4'd6,
        aluSubC  = 4'd7,
        aluShl   = 4'd8,
        aluShr   = 4'd9,
        aluRol   = 4'd10,
        aluRor   = 4'd11,
        aluNot   = 4'd12,
        aluPassA = 4'd13
    } aluMode_e;

    typedef enum logic [2:0] {
        stIdle,
        stExecute,
        stDataWait,     // second cycle of IN and load
        stJumpLoad,
        stCallHigh,
        stRetPop,
        stRetLoad
    } step_e;

    typedef enum logic [2:0] {
        selPcPlusOne  = 3'd0,   // skips the address word
        selPcOut      = 3'd1,
        selInstrWord  = 3'd3,
        selPairAddr   = 3'd4,
        selReturnAddr = 3'd5
    } iMemAddrSel_e;

    typedef enum logic [2:0] {
        selPcHigh = 3'd0,
        selPcLow  = 3'd1,
        selAluOut = 3'd2
    } dMemDataSel_e;

    typedef enum logic [1:0] {
        selPairPtr        = 2'd0,
        selPortAddr       = 2'd1,
        selPairPtrPlusOne = 2'd2
    } dMemAddrSel_e;

    typedef enum logic [1:0] {
        selAluResult = 2'd0,
        selMemData   = 2'd2
    } regFileSrc_e;

endpackage
